// File: all.f
design/alu_pkg.sv
design/alu_ram_if.sv
design/alu_cmd_if.sv
design/alu_axil_regs.sv
design/alu_seq_fsm.sv
design/alu_word_cnt.sv
design/alu_word_engine.sv
design/alu_op_ram.sv
design/alu_top.sv
tb/alu_checker.sv
tb/tb_alu.sv

// File: tb/tb_alu.sv
// multiword alu testbench with clock, reset, random AXI4-Lite stimulus and test sequence
`timescale 1ns/100ps

module tb_alu;
    import alu_pkg::*;

    localparam int NWORDS = 64;
    localparam int IW = $clog2(NWORDS);
    localparam int NTESTS = 6;
    localparam real WATCHDOG_NS = NTESTS * (2 * NWORDS + NWORDS + 3 * NWORDS + 1) * 8 * 4.0;

    logic clk = 1'b0;
    logic rst_n;
    logic [AXIL_AW-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    word_t wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic busy, done;
    logic [31:0] lfsr_q = 32'h72cd_ab2d;
    int tests_run = 0;

    always #2 clk = ~clk;

    alu_top #(.NWORDS(NWORDS)) dut (
        .clk, .rst_n,
        .s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
        .s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
        .s_axil_wready(wready), .s_axil_bresp(bresp), .s_axil_bvalid(bvalid),
        .s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
        .s_axil_arready(arready), .s_axil_rdata(rdata), .s_axil_rresp(rresp),
        .s_axil_rvalid(rvalid), .s_axil_rready(rready), .busy, .done
    );

    alu_checker #(.NWORDS(NWORDS)) chk (
        .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .busy, .done
    );

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [AXIL_AW-1:0] win_addr(input logic [1:0] seg,
                                                   input logic [IW-1:0] idx);
        logic [AXIL_AW-1:0] a;
        a = AXIL_AW'({seg, idx});
        return RAM_WINDOW | (a << 2);
    endfunction

    task automatic axi_write(input logic [AXIL_AW-1:0] a, input word_t d);
        logic hs;
        @(negedge clk);
        awaddr = a;
        wdata = d;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do begin
            #1 hs = awready;
            @(posedge clk);
        end while (!hs);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
    endtask

    task automatic axi_read(input logic [AXIL_AW-1:0] a, output word_t d);
        logic hs;
        @(negedge clk);
        araddr = a;
        arvalid = 1'b1;
        do begin
            #1 hs = arready;
            @(posedge clk);
        end while (!hs);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        d = rdata;
    endtask

    task automatic wait_idle();
        word_t st;
        do axi_read(REG_STATUS, st); while (st[0]);
    endtask

    // mode 1 forces A below B in the top word and mode 2 forces the reverse
    task automatic load_operands(input int n, input int mode);
        word_t a, b;
        for (int i = 0; i < n; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            if (i == n - 1 && mode == 1) begin
                a[31] = 1'b0;
                b[31] = 1'b1;
            end else if (i == n - 1 && mode == 2) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            axi_write(win_addr(SEG_A, IW'(i)), a);
            axi_write(win_addr(SEG_B, IW'(i)), b);
        end
    endtask

    task automatic run_op(input logic [7:0] f, input logic [1:0] op, input logic [IW-1:0] len);
        axi_write(REG_FUNC, 32'(f));
        axi_write(REG_OPT, 32'(op));
        axi_write(REG_LEN, 32'(len));
        axi_write(REG_START, 32'(START_KEY));
        wait_idle();
    endtask

    task automatic read_seg(input logic [1:0] seg);
        word_t d;
        for (int i = 0; i < NWORDS; i++) axi_read(win_addr(seg, IW'(i)), d);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s finished, errors so far %0d", tests_run, name, chk.errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [IW-1:0] len;
        word_t d;
        rst_n = 1'b0;
        {awaddr, araddr, wdata} = '0;
        {awvalid, wvalid, arvalid} = '0;
        wstrb = 4'hf;
        bready = 1'b1;
        rready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // known contents everywhere so later compares never meet X
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < NWORDS; i++) axi_write(win_addr(2'(s), IW'(i)), rand_bits(32));
        end

        axi_write(REG_FUNC, rand_bits(32));
        axi_write(REG_LEN, rand_bits(32));
        axi_write(REG_OPT, rand_bits(32));
        axi_read(REG_FUNC, d);
        axi_read(REG_LEN, d);
        axi_read(REG_OPT, d);
        axi_read(15'h0020, d);
        axi_write(15'h0024, rand_bits(32));
        finish_test("register readback");

        len = IW'(rand_bits(IW));
        load_operands(len == 0 ? NWORDS : len, 0);
        run_op(FUNC_ADD, 2'd0, len);
        read_seg(SEG_C);
        axi_read(REG_FLAGS, d);
        axi_write(REG_FLAGS, 32'h1);
        axi_read(REG_FLAGS, d);
        finish_test("add");

        for (int m = 1; m <= 2; m++) begin
            len = IW'(rand_bits(IW));
            load_operands(len == 0 ? NWORDS : len, m);
            run_op(FUNC_SUB, 2'd0, len);
            read_seg(SEG_C);
            axi_read(REG_STATUS, d);
        end
        finish_test("sub");

        len = IW'(rand_bits(IW));
        load_operands(len == 0 ? NWORDS : len, 0);
        for (int op = 0; op < 4; op++) begin
            run_op(FUNC_BLG, 2'(op), len);
            read_seg(SEG_C);
            len = IW'(len - 1);
        end
        finish_test("logic");

        axi_write(REG_FLAGS, 32'h3);
        run_op(8'h77, 2'd0, IW'(rand_bits(IW)));
        axi_read(REG_FLAGS, d);
        read_seg(SEG_C);
        axi_write(REG_FLAGS, 32'h3);
        finish_test("bad function");

        axi_write(REG_FUNC, 32'(FUNC_ADD));
        axi_write(REG_LEN, 32'h0);
        axi_write(REG_START, 32'(START_KEY));
        axi_write(win_addr(SEG_A, '0), rand_bits(32));
        axi_read(win_addr(SEG_B, '0), d);
        wait_idle();
        axi_read(win_addr(SEG_A, '0), d);
        finish_test("window while busy");

        repeat (4) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, chk.checks, chk.errors);
        if (chk.errors == 0 && chk.checks > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb/alu_checker.sv
// alu checker that snoops the AXI4-Lite ports and models registers and ram
`timescale 1ns/100ps

module alu_checker #(
    parameter int NWORDS = 64
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic [alu_pkg::AXIL_AW-1:0] awaddr,
    input logic                        awvalid,
    input logic                        awready,
    input alu_pkg::word_t              wdata,
    input logic                        wvalid,
    input logic                        wready,
    input logic [1:0]                  bresp,
    input logic                        bvalid,
    input logic                        bready,
    input logic [alu_pkg::AXIL_AW-1:0] araddr,
    input logic                        arvalid,
    input logic                        arready,
    input alu_pkg::word_t              rdata,
    input logic [1:0]                  rresp,
    input logic                        rvalid,
    input logic                        rready,
    input logic                        busy,
    input logic                        done
);
    import alu_pkg::*;

    localparam int IW = $clog2(NWORDS);

    word_t mem [0:3*NWORDS-1];
    logic [7:0] func_m;
    logic [IW-1:0] len_m;
    logic [1:0] opt_m;
    logic flag_done, flag_err, carry_m, bad_run;
    logic bvalid_m, rvalid_m, win_wait;
    int busy_left;
    word_t rd_exp, rd_mask;
    logic [1:0] rresp_exp, bresp_exp;
    int errors = 0;
    int checks = 0;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // whole result computed at start while the DUT walks it word by word
    task automatic launch();
        int n;
        logic [32:0] r;
        word_t a, b;
        logic c;
        n = (len_m == 0) ? NWORDS : len_m;
        c = 1'b0;
        bad_run = !(func_m == 8'h02 || func_m == 8'h03 || func_m == 8'h32);
        for (int i = 0; i < n && !bad_run; i++) begin
            a = mem[i];
            b = mem[NWORDS + i];
            if (func_m == 8'h02) r = {1'b0, a} + {1'b0, b} + 33'(c);
            else if (func_m == 8'h03) r = {1'b0, a} - {1'b0, b} - 33'(c);
            else if (opt_m == 2'd0) r = {1'b0, a & b};
            else if (opt_m == 2'd1) r = {1'b0, a | b};
            else r = {1'b0, a ^ b};
            c = r[32];
            mem[2 * NWORDS + i] = r[31:0];
        end
        carry_m = c;
        busy_left = bad_run ? 1 : 3 * n + 1;
    endtask

    always @(posedge clk or negedge rst_n) begin : model
        logic busy_now, done_now, win, err, clr_done, clr_err, go;
        logic wr_acc_exp;
        logic [1:0] seg;
        int idx;
        if (!rst_n) begin
            {func_m, len_m, opt_m} = '0;
            {flag_done, flag_err, carry_m, bad_run} = '0;
            {bvalid_m, rvalid_m, win_wait} = '0;
            busy_left = 0;
        end else begin
            busy_now = busy_left > 0;
            done_now = busy_left == 1;
            // a write is taken with both valids and no response waiting
            wr_acc_exp = awvalid && wvalid && !bvalid_m;
            compare("busy", 32'(busy_now), 32'(busy));
            compare("done", 32'(done_now), 32'(done));
            compare("s_axil_awready", 32'(wr_acc_exp), 32'(awready));
            compare("s_axil_wready", 32'(wr_acc_exp), 32'(wready));
            compare("s_axil_bvalid", 32'(bvalid_m), 32'(bvalid));
            compare("s_axil_arready", 32'(arvalid && !rvalid_m && !win_wait), 32'(arready));
            compare("s_axil_rvalid", 32'(rvalid_m), 32'(rvalid));
            if (rvalid && rready) begin
                compare("s_axil_rdata", rd_exp & rd_mask, rdata & rd_mask);
                compare("s_axil_rresp", 32'(rresp_exp), 32'(rresp));
            end
            if (bvalid && bready) compare("s_axil_bresp", 32'(bresp_exp), 32'(bresp));
            if (arvalid && arready) begin
                win = araddr[12];
                seg = araddr[IW+3:IW+2];
                idx = int'(seg) * NWORDS + int'(araddr[IW+1:2]);
                rd_mask = '1;
                rd_exp = '0;
                err = win ? (busy_now || seg == 2'd3) : 1'b0;
                if (win && !err) rd_exp = mem[idx];
                else if (!win) begin
                    case (araddr)
                        REG_FUNC: rd_exp = 32'(func_m);
                        REG_LEN: rd_exp = 32'(len_m);
                        REG_OPT: rd_exp = 32'(opt_m);
                        REG_START: rd_exp = '0;
                        REG_FLAGS: rd_exp = {30'd0, flag_err, flag_done};
                        REG_STATUS: begin
                            rd_exp = {30'd0, carry_m, busy_now};
                            // carry only settles once the run is over
                            if (busy_now) rd_mask = 32'hffff_fffd;
                        end
                        default: err = 1'b1;
                    endcase
                end
                rresp_exp = err ? 2'b10 : 2'b00;
                // window reads spend one more cycle in the ram
                win_wait = win && !err;
                rvalid_m = !(win && !err);
            end else if (win_wait) begin
                win_wait = 1'b0;
                rvalid_m = 1'b1;
            end else if (rready) begin
                rvalid_m = 1'b0;
            end
            clr_done = 1'b0;
            clr_err = 1'b0;
            go = 1'b0;
            if (awvalid && wvalid && awready) begin
                win = awaddr[12];
                seg = awaddr[IW+3:IW+2];
                idx = int'(seg) * NWORDS + int'(awaddr[IW+1:2]);
                err = win ? (busy_now || seg == 2'd3) : 1'b0;
                if (win && !err) mem[idx] = wdata;
                else if (!win) begin
                    case (awaddr)
                        REG_FUNC: func_m = wdata[7:0];
                        REG_LEN: len_m = wdata[IW-1:0];
                        REG_OPT: opt_m = wdata[1:0];
                        REG_START: go = (wdata[7:0] == 8'h5a) && !busy_now;
                        REG_FLAGS: {clr_err, clr_done} = wdata[1:0];
                        REG_STATUS: ;
                        default: err = 1'b1;
                    endcase
                end
                bresp_exp = err ? 2'b10 : 2'b00;
            end
            bvalid_m = (awvalid && wvalid && awready) || (bvalid_m && !bready);
            flag_done = done_now | (flag_done & ~clr_done);
            flag_err = (done_now & bad_run) | (flag_err & ~clr_err);
            if (busy_left > 0) busy_left--;
            if (go) launch();
        end
    end

endmodule

// File: design/alu_top.sv
// multiword alu top: AXI4-Lite registers, sequencer, counter, word engine and operand ram
`timescale 1ns/100ps

module alu_top #(
    parameter int NWORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [alu_pkg::AXIL_AW-1:0]   s_axil_awaddr,
    input  logic                          s_axil_awvalid,
    output logic                          s_axil_awready,
    input  alu_pkg::word_t                s_axil_wdata,
    // full-word writes only, strobes have no effect
    input  logic [3:0]                    s_axil_wstrb,
    input  logic                          s_axil_wvalid,
    output logic                          s_axil_wready,
    output logic [1:0]                    s_axil_bresp,
    output logic                          s_axil_bvalid,
    input  logic                          s_axil_bready,
    input  logic [alu_pkg::AXIL_AW-1:0]   s_axil_araddr,
    input  logic                          s_axil_arvalid,
    output logic                          s_axil_arready,
    output alu_pkg::word_t                s_axil_rdata,
    output logic [1:0]                    s_axil_rresp,
    output logic                          s_axil_rvalid,
    input  logic                          s_axil_rready,
    output logic                          busy,
    output logic                          done
);
    import alu_pkg::*;

    logic                      last;
    logic                      step;
    logic                      carry_clr;
    logic [$clog2(NWORDS)-1:0] idx;
    seq_state_e                phase;

    alu_cmd_if #(.NWORDS(NWORDS)) cmd_if ();
    alu_ram_if #(.NWORDS(NWORDS)) host_if ();
    alu_ram_if #(.NWORDS(NWORDS)) eng_if ();

    alu_axil_regs #(.NWORDS(NWORDS)) u_regs (
        .clk,
        .rst_n,
        .s_axil_awaddr,
        .s_axil_awvalid,
        .s_axil_awready,
        .s_axil_wdata,
        .s_axil_wvalid,
        .s_axil_wready,
        .s_axil_bresp,
        .s_axil_bvalid,
        .s_axil_bready,
        .s_axil_araddr,
        .s_axil_arvalid,
        .s_axil_arready,
        .s_axil_rdata,
        .s_axil_rresp,
        .s_axil_rvalid,
        .s_axil_rready,
        .cmd        (cmd_if.regs),
        .ram        (host_if.host)
    );

    alu_seq_fsm #(.NWORDS(NWORDS)) u_seq (
        .clk,
        .rst_n,
        .cmd        (cmd_if.seq),
        .ram        (eng_if.host),
        .last,
        .idx,
        .step,
        .carry_clr,
        .phase
    );

    alu_word_cnt #(.NWORDS(NWORDS)) u_cnt (
        .clk,
        .rst_n,
        .cmd        (cmd_if.cnt),
        .step,
        .idx,
        .last
    );

    // sequencer drives the engine port address, the engine its write data
    alu_word_engine u_eng (
        .clk,
        .rst_n,
        .func       (cmd_if.run_func),
        .opt        (cmd_if.run_opt),
        .phase,
        .carry_clr,
        .rdat       (eng_if.rdat),
        .wdat       (eng_if.wdat),
        .carry      (cmd_if.carry)
    );

    alu_op_ram #(.NWORDS(NWORDS)) u_ram (
        .clk,
        .eng        (eng_if.ram),
        .host       (host_if.ram)
    );

    assign busy = cmd_if.busy;
    assign done = cmd_if.done;

endmodule

// File: design/alu_op_ram.sv
// operand ram: segments A, B and C in one array, engine port ahead of host port
`timescale 1ns/100ps

module alu_op_ram #(
    parameter int NWORDS = 64
) (
    input  logic                          clk,
    alu_ram_if.ram                        eng,
    alu_ram_if.ram                        host
);
    import alu_pkg::*;

    localparam int AW = $clog2(NWORDS) + 2;

    word_t         mem [0:3*NWORDS-1];
    word_t         rdat_q;
    logic          use_eng;
    logic [AW-1:0] addr;
    logic          rd;
    logic          wr;
    word_t         wdat;

    // engine gets the array whenever it asks
    assign use_eng = eng.rd | eng.wr;
    assign addr    = use_eng ? eng.addr : host.addr;
    assign rd      = use_eng ? eng.rd   : host.rd;
    assign wr      = use_eng ? eng.wr   : host.wr;
    assign wdat    = use_eng ? eng.wdat : host.wdat;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdat;
        end
        if (rd) begin
            rdat_q <= mem[addr];
        end
    end

    assign eng.rdat  = rdat_q;
    assign host.rdat = rdat_q;

endmodule

// File: design/alu_word_engine.sv
// word engine: holds the A word and carry, combines A with B into one result word
`timescale 1ns/100ps

module alu_word_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  alu_pkg::alu_func_e            func,
    input  alu_pkg::logic_op_e            opt,
    input  alu_pkg::seq_state_e           phase,
    input  logic                          carry_clr,
    input  alu_pkg::word_t                rdat,
    output alu_pkg::word_t                wdat,
    output logic                          carry
);
    import alu_pkg::*;

    word_t a_q;
    logic  carry_q;
    logic  carry_nxt;

    // A word lands on rdat while B is being read
    always_ff @(posedge clk) begin
        if (phase == S_RD_B) begin
            a_q <= rdat;
        end
    end

    // rdat holds B during the write cycle
    always_comb begin
        carry_nxt = 1'b0;
        case (func)
            FUNC_ADD: {carry_nxt, wdat} = {1'b0, a_q} + {1'b0, rdat} + 33'(carry_q);
            // top bit of the 33-bit difference is the borrow
            FUNC_SUB: {carry_nxt, wdat} = {1'b0, a_q} - {1'b0, rdat} - 33'(carry_q);
            FUNC_BLG: begin
                case (opt)
                    LOP_AND: wdat = a_q & rdat;
                    LOP_OR:  wdat = a_q | rdat;
                    default: wdat = a_q ^ rdat;
                endcase
            end
            default: wdat = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (carry_clr) begin
            carry_q <= 1'b0;
        end else if (phase == S_WR) begin
            carry_q <= carry_nxt;
        end
    end

    assign carry = carry_q;

endmodule

// File: design/alu_word_cnt.sv
// word counter: operand word index for the run, flags the last word
`timescale 1ns/100ps

module alu_word_cnt #(
    parameter int NWORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    alu_cmd_if.cnt                        cmd,
    input  logic                          step,
    output logic [$clog2(NWORDS)-1:0]     idx,
    output logic                          last
);

    localparam int IW = $clog2(NWORDS);

    logic [IW-1:0] len_m1;

    // len 0 wraps to NWORDS-1, a full operand
    assign len_m1 = cmd.len - IW'(1);
    assign last   = (idx == len_m1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (cmd.start) begin
            idx <= '0;
        end else if (step) begin
            idx <= idx + IW'(1);
        end
    end

endmodule

// File: design/alu_seq_fsm.sv
// alu sequencer: walks each word through read A, read B and write C, then done
`timescale 1ns/100ps

module alu_seq_fsm #(
    parameter int NWORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    alu_cmd_if.seq                        cmd,
    alu_ram_if.host                       ram,
    input  logic                          last,
    input  logic [$clog2(NWORDS)-1:0]     idx,
    output logic                          step,
    output logic                          carry_clr,
    output alu_pkg::seq_state_e           phase
);
    import alu_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    alu_func_e  func_q;
    logic_op_e  opt_q;
    logic [1:0] seg;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                // bad function code skips straight to done
                if (cmd.start) state_nxt = func_valid(cmd.func) ? S_RD_A : S_DONE;
            end
            S_RD_A: state_nxt = S_RD_B;
            S_RD_B: state_nxt = S_WR;
            S_WR:   state_nxt = last ? S_DONE : S_RD_A;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            func_q <= FUNC_ADD;
            opt_q  <= LOP_AND;
        end else begin
            state <= state_nxt;
            if (state == S_IDLE && cmd.start) begin
                func_q <= cmd.func;
                opt_q  <= cmd.opt;
            end
        end
    end

    always_comb begin
        case (state)
            S_RD_A:  seg = SEG_A;
            S_RD_B:  seg = SEG_B;
            default: seg = SEG_C;
        endcase
    end

    assign ram.addr = {seg, idx};
    assign ram.rd   = (state == S_RD_A) || (state == S_RD_B);
    assign ram.wr   = (state == S_WR);

    assign step      = (state == S_WR);
    assign carry_clr = (state == S_IDLE) && cmd.start;
    assign phase     = state;

    assign cmd.busy     = (state != S_IDLE);
    assign cmd.done     = (state == S_DONE);
    assign cmd.func_err = (state == S_DONE) && !func_valid(func_q);
    assign cmd.run_func = func_q;
    assign cmd.run_opt  = opt_q;

endmodule

// File: design/alu_axil_regs.sv
// alu register block: AXI4-Lite slave with control, status, flags and the ram window
`timescale 1ns/100ps

module alu_axil_regs #(
    parameter int NWORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [alu_pkg::AXIL_AW-1:0]   s_axil_awaddr,
    input  logic                          s_axil_awvalid,
    output logic                          s_axil_awready,
    input  alu_pkg::word_t                s_axil_wdata,
    input  logic                          s_axil_wvalid,
    output logic                          s_axil_wready,
    output logic [1:0]                    s_axil_bresp,
    output logic                          s_axil_bvalid,
    input  logic                          s_axil_bready,
    input  logic [alu_pkg::AXIL_AW-1:0]   s_axil_araddr,
    input  logic                          s_axil_arvalid,
    output logic                          s_axil_arready,
    output alu_pkg::word_t                s_axil_rdata,
    output logic [1:0]                    s_axil_rresp,
    output logic                          s_axil_rvalid,
    input  logic                          s_axil_rready,
    alu_cmd_if.regs                       cmd,
    alu_ram_if.host                       ram
);
    import alu_pkg::*;

    localparam int IW = $clog2(NWORDS);

    logic [7:0]    func_q;
    logic [IW-1:0] len_q;
    logic [1:0]    opt_q;
    logic          flag_done;
    logic          flag_err;

    logic          wr_acc;
    logic          wr_win;
    logic          wr_err;
    logic          wr_ram;
    logic          wr_reg;
    logic          flags_wr;
    logic          rd_acc;
    logic          rd_win;
    logic          rd_err;
    logic          rd_ram;
    logic          win_pend;
    word_t         reg_rdata;

    function automatic logic reg_hit(input logic [AXIL_AW-1:0] a);
        return a inside {REG_FUNC, REG_START, REG_STATUS, REG_FLAGS, REG_LEN, REG_OPT};
    endfunction

    // write side, address and data taken together
    assign wr_acc = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
    assign s_axil_awready = wr_acc;
    assign s_axil_wready  = wr_acc;

    assign wr_win = |(s_axil_awaddr & RAM_WINDOW);
    assign wr_err = wr_win ? (cmd.busy | (s_axil_awaddr[IW+3:IW+2] > SEG_C))
                           : ~reg_hit(s_axil_awaddr);
    assign wr_ram   = wr_acc & wr_win & ~wr_err;
    assign wr_reg   = wr_acc & ~wr_win & ~wr_err;
    assign flags_wr = wr_reg & (s_axil_awaddr == REG_FLAGS);

    // read side, held off while the write owns the ram port
    assign rd_win = |(s_axil_araddr & RAM_WINDOW);
    assign rd_err = rd_win ? (cmd.busy | (s_axil_araddr[IW+3:IW+2] > SEG_C))
                           : ~reg_hit(s_axil_araddr);
    assign rd_acc = s_axil_arvalid & ~s_axil_rvalid & ~win_pend & ~(rd_win & wr_ram);
    assign rd_ram = rd_acc & rd_win & ~rd_err;
    assign s_axil_arready = rd_acc;

    assign ram.wr   = wr_ram;
    assign ram.rd   = rd_ram;
    assign ram.addr = wr_ram ? s_axil_awaddr[IW+3:2] : s_axil_araddr[IW+3:2];
    assign ram.wdat = s_axil_wdata;

    assign cmd.start = wr_reg & (s_axil_awaddr == REG_START) &
                       (s_axil_wdata[7:0] == START_KEY) & ~cmd.busy;
    assign cmd.func  = alu_func_e'(func_q);
    assign cmd.opt   = logic_op_e'(opt_q);
    assign cmd.len   = len_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            func_q    <= '0;
            len_q     <= '0;
            opt_q     <= '0;
            flag_done <= 1'b0;
            flag_err  <= 1'b0;
        end else begin
            if (wr_reg) begin
                case (s_axil_awaddr)
                    REG_FUNC: func_q <= s_axil_wdata[7:0];
                    REG_LEN:  len_q  <= s_axil_wdata[IW-1:0];
                    REG_OPT:  opt_q  <= s_axil_wdata[1:0];
                    default:  ;
                endcase
            end
            // sticky, write one to clear, a new event wins
            flag_done <= cmd.done | (flag_done & ~(flags_wr & s_axil_wdata[0]));
            flag_err  <= cmd.func_err | (flag_err & ~(flags_wr & s_axil_wdata[1]));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axil_bvalid <= 1'b0;
            s_axil_bresp  <= RESP_OKAY;
        end else if (wr_acc) begin
            s_axil_bvalid <= 1'b1;
            s_axil_bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (s_axil_araddr)
            REG_FUNC:   reg_rdata[7:0]    = func_q;
            REG_STATUS: reg_rdata[1:0]    = {cmd.carry, cmd.busy};
            REG_FLAGS:  reg_rdata[1:0]    = {flag_err, flag_done};
            REG_LEN:    reg_rdata[IW-1:0] = len_q;
            REG_OPT:    reg_rdata[1:0]    = opt_q;
            default:    ;
        endcase
    end

    // window reads spend one extra cycle on the ram
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_pend      <= 1'b0;
            s_axil_rvalid <= 1'b0;
            s_axil_rresp  <= RESP_OKAY;
        end else begin
            win_pend <= rd_ram;
            if (rd_acc & ~rd_ram) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
            end else if (win_pend) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rresp  <= RESP_OKAY;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win_pend) begin
            s_axil_rdata <= ram.rdat;
        end else if (rd_acc & ~rd_ram) begin
            s_axil_rdata <= rd_err ? '0 : reg_rdata;
        end
    end

endmodule

// File: design/alu_cmd_if.sv
// alu command and status: run setup from the register block, run state back
`timescale 1ns/100ps

interface alu_cmd_if #(
    parameter int NWORDS = 64
);
    import alu_pkg::*;

    localparam int IW = $clog2(NWORDS);

    logic            start;
    alu_func_e       func;
    logic_op_e       opt;
    logic [IW-1:0]   len;

    logic            busy;
    logic            done;
    logic            carry;
    logic            func_err;

    // copies held by the sequencer for the whole run
    alu_func_e       run_func;
    logic_op_e       run_opt;

    modport regs (
        output start, func, opt, len,
        input  busy, done, carry, func_err
    );

    modport seq (
        input  start, func, opt,
        output busy, done, func_err, run_func, run_opt
    );

    modport cnt (input start, len);

endinterface

// File: design/alu_ram_if.sv
// operand ram access port: word address, read and write strobes, data both ways
`timescale 1ns/100ps

interface alu_ram_if #(
    parameter int NWORDS = 64
);
    import alu_pkg::*;

    // segment number on top of the word index
    localparam int AW = $clog2(NWORDS) + 2;

    logic [AW-1:0] addr;
    logic          rd;
    logic          wr;
    word_t         wdat;
    word_t         rdat;

    modport host (output addr, rd, wr, wdat, input rdat);
    modport ram  (input addr, rd, wr, wdat, output rdat);

endinterface

// File: design/alu_pkg.sv
// alu package: word type, function codes, register map and sequencer states
package alu_pkg;

    localparam int AXIL_AW = 15;

    typedef logic [31:0] word_t;

    typedef enum logic [7:0] {
        FUNC_ADD = 8'h02,
        FUNC_SUB = 8'h03,
        FUNC_BLG = 8'h32
    } alu_func_e;

    // 3 is not listed and falls through to xor
    typedef enum logic [1:0] {
        LOP_AND = 2'd0,
        LOP_OR  = 2'd1,
        LOP_XOR = 2'd2
    } logic_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_RD_B,
        S_WR,
        S_DONE
    } seq_state_e;

    localparam logic [7:0] START_KEY = 8'h5a;

    localparam logic [AXIL_AW-1:0] REG_FUNC   = 15'h0000;
    localparam logic [AXIL_AW-1:0] REG_START  = 15'h0004;
    localparam logic [AXIL_AW-1:0] REG_STATUS = 15'h0008;
    localparam logic [AXIL_AW-1:0] REG_FLAGS  = 15'h000c;
    localparam logic [AXIL_AW-1:0] REG_LEN    = 15'h0010;
    localparam logic [AXIL_AW-1:0] REG_OPT    = 15'h0014;
    localparam logic [AXIL_AW-1:0] RAM_WINDOW = 15'h1000;

    // operand ram segments, sit above the word index
    localparam logic [1:0] SEG_A = 2'd0;
    localparam logic [1:0] SEG_B = 2'd1;
    localparam logic [1:0] SEG_C = 2'd2;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    function automatic logic func_valid(input alu_func_e f);
        return f inside {FUNC_ADD, FUNC_SUB, FUNC_BLG};
    endfunction

endpackage
